// ==== filelist.f ====
+incdir+hw
hw/mister_pkg.sv
hw/joy_merge.sv
hw/sync_offset.sv
hw/ddr_arbiter.sv
hw/mister_frame.sv
tests/mister_frame_asserts.sv
tests/tb_mister_frame.sv

// ==== Bender.yml ====
package:
  name: mister_frame

sources:
  - include_dirs:
      - hw
    files:
      - hw/mister_pkg.sv
      - hw/joy_merge.sv
      - hw/sync_offset.sv
      - hw/ddr_arbiter.sv
      - hw/mister_frame.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/mister_frame_asserts.sv
      - tests/tb_mister_frame.sv

// ==== tests/tb_mister_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mister_defs.svh"

module tb_mister_frame;

    localparam int RESET_CYCLES = 16;
    localparam int JOY_CYCLES   = 300;
    localparam int SYNC_CYCLES  = 3000;
    localparam int DDR_CYCLES   = 600;
    localparam int RUN_CYCLES   = RESET_CYCLES + JOY_CYCLES + SYNC_CYCLES + DDR_CYCLES + 40;

    logic                   clk_sys;
    logic                   clk_rom;
    logic                   arst_n;
    logic [`STATUS_W-1:0]   status;
    mister_pkg::db15_pair_t db15;
    mister_pkg::joy_word_t  usb_joy1;
    mister_pkg::joy_word_t  usb_joy2;
    mister_pkg::joy_word_t  usb_joy3;
    mister_pkg::joy_word_t  usb_joy4;
    wire mister_pkg::joy_word_t game_joy1;
    wire mister_pkg::joy_word_t game_joy2;
    wire mister_pkg::joy_word_t game_joy3;
    wire mister_pkg::joy_word_t game_joy4;
    logic                   pxl_cen;
    mister_pkg::sync_t      game_sync;
    wire mister_pkg::sync_t sync_out;
    logic                   downloading;
    logic                   ddram_busy;
    mister_pkg::ddr_req_t   ld_req;
    mister_pkg::ddr_req_t   rot_req;
    wire mister_pkg::ddr_req_t ddr_req;
    wire                    ld_busy;
    wire                    rot_busy;

    logic [31:0]            rng;
    int                     tb_errors;
    int                     total_errors;

    mister_frame mister_frame_inst (.*);

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Random DDR command with rd and we cleared
    function automatic mister_pkg::ddr_req_t idle_req();
        logic [127:0]         bits;
        mister_pkg::ddr_req_t r;
        bits = {next_random(), next_random(), next_random(), next_random()};
        r    = bits[$bits(mister_pkg::ddr_req_t)-1:0];
        r.rd = 1'b0;
        r.we = 1'b0;
        return r;
    endfunction

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    initial begin
        clk_rom = 1'b0;
        forever #5 clk_rom = ~clk_rom;
    end

    // Pixel strobe on one clock in three
    initial begin : pixel_strobe
        int phase;
        phase   = 0;
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk_sys);
            phase   = (phase == 2) ? 0 : phase + 1;
            pxl_cen = (phase == 0);
        end
    end

    initial begin : watchdog
        #(RUN_CYCLES * 10 + 2000);
        $display("Timeout: the run did not finish within %0d ns", RUN_CYCLES * 10 + 2000);
        $display("Checks failed");
        $finish;
    end

    task automatic joy_phase();
        logic [31:0] r;
        for (int i = 0; i < JOY_CYCLES; i++) begin
            @(negedge clk_sys);
            r = next_random();
            usb_joy1 = r[15:0];
            usb_joy2 = r[31:16];
            r = next_random();
            usb_joy3 = r[15:0];
            usb_joy4 = r[31:16];
            r = next_random();
            db15.joy1 = r[15:0];
            db15.joy2 = r[31:16];
            // Last cycles hold start plus button 5 with coin low
            if (i >= JOY_CYCLES - 20) begin
                db15.joy1 = 16'h37e5;
                db15.joy2 = 16'h37e5;
            end
            r = next_random();
            // First third keeps both DB15 ports off
            db15.ena1 = (i >= JOY_CYCLES / 3) & r[0];
            db15.ena2 = (i >= JOY_CYCLES / 3) & r[1];
        end
    endtask

    task automatic sync_phase();
        logic [31:0] r;
        for (int i = 0; i < SYNC_CYCLES; i++) begin
            @(negedge clk_sys);
            if (i % 64 == 0) begin
                status = {next_random(), next_random()};
            end
            r = next_random();
            if (r[3:2] == 2'd0) begin
                game_sync.hs = ~game_sync.hs;
            end
            if (r[9:5] == 5'd0) begin
                game_sync.vs = ~game_sync.vs;
            end
        end
    endtask

    task automatic ddr_phase();
        logic [31:0] r;
        int          wait_cnt;
        rot_req    = idle_req();
        ld_req     = idle_req();
        ddram_busy = 1'b0;
        @(negedge clk_rom);
        downloading = 1'b1;
        wait_cnt    = 0;
        while (ld_busy !== 1'b0 && wait_cnt < 8) begin
            @(negedge clk_rom);
            wait_cnt++;
        end
        if (ld_busy !== 1'b0) begin
            tb_errors++;
            $display("Loader was never granted the DDR port after downloading rose");
        end
        // Loader read in flight while downloading drops
        ld_req.rd = 1'b1;
        @(negedge clk_rom);
        downloading = 1'b0;
        repeat (5) @(negedge clk_rom);
        ld_req.rd = 1'b0;
        repeat (3) @(negedge clk_rom);
        // Rotator write in flight while downloading rises
        rot_req.we  = 1'b1;
        downloading = 1'b1;
        repeat (5) @(negedge clk_rom);
        rot_req.we = 1'b0;
        repeat (3) @(negedge clk_rom);
        for (int i = 0; i < DDR_CYCLES; i++) begin
            @(negedge clk_rom);
            r = next_random();
            if (!ld_busy) begin
                ld_req    = idle_req();
                ld_req.rd = r[6];
                ld_req.we = r[7] & ~r[6];
            end
            if (!rot_busy) begin
                rot_req    = idle_req();
                rot_req.rd = r[8];
                rot_req.we = r[9] & ~r[8];
            end
            if (r[5:1] == 5'd0) begin
                downloading = ~downloading;
            end
            ddram_busy = r[0];
        end
    endtask

    initial begin
        rng         = 32'h1de81a92;
        tb_errors   = 0;
        arst_n      = 1'b0;
        status      = '0;
        db15        = '0;
        usb_joy1    = '0;
        usb_joy2    = '0;
        usb_joy3    = '0;
        usb_joy4    = '0;
        game_sync   = '0;
        downloading = 1'b0;
        ddram_busy  = 1'b0;
        // Two different idle requests so the owner after reset shows on ddr_req
        ld_req      = idle_req();
        rot_req     = idle_req();
        repeat (RESET_CYCLES) @(negedge clk_sys);
        arst_n = 1'b1;
        joy_phase();
        sync_phase();
        ddr_phase();
        repeat (4) @(negedge clk_sys);
        total_errors = tb_errors + mister_frame_inst.u_asserts.fail_count;
        $display("Errors: %0d from assertions, %0d from testbench",
                 mister_frame_inst.u_asserts.fail_count, tb_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/mister_frame_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mister_defs.svh"

module mister_frame_asserts (
    input wire                         clk_sys,
    input wire                         clk_rom,
    input wire                         arst_n,
    input wire                         pxl_cen,
    input wire [`OFS_W-1:0]            hoffset,
    input wire [`OFS_W-1:0]            voffset,
    input wire mister_pkg::sync_t      game_sync,
    input wire mister_pkg::sync_t      sync_out,
    input wire mister_pkg::db15_pair_t db15,
    input wire mister_pkg::joy_word_t  usb_joy1,
    input wire mister_pkg::joy_word_t  usb_joy2,
    input wire mister_pkg::joy_word_t  usb_joy3,
    input wire mister_pkg::joy_word_t  usb_joy4,
    input wire mister_pkg::joy_word_t  game_joy1,
    input wire mister_pkg::joy_word_t  game_joy2,
    input wire mister_pkg::joy_word_t  game_joy3,
    input wire mister_pkg::joy_word_t  game_joy4,
    input wire                         downloading,
    input wire                         ddram_busy,
    input wire mister_pkg::ddr_req_t   ld_req,
    input wire mister_pkg::ddr_req_t   rot_req,
    input wire mister_pkg::ddr_req_t   ddr_req,
    input wire                         ld_busy,
    input wire                         rot_busy
);

    localparam int RING = 1 << `OFS_W;

    int fail_count = 0;

    // Game layout of a raw DB15 word, bit by bit
    function automatic logic [`JOY_W-1:0] game_layout(input logic [`JOY_W-1:0] raw);
        logic [`JOY_W-1:0] w;
        for (int i = 0; i < `JOY_W; i++) begin
            w[i] = (i < 4 + `BUTTONS) ? raw[i] : 1'b0;
        end
        w[14] = raw[10];
        w[15] = raw[11] | (raw[10] & raw[5]);
        return w;
    endfunction

    mister_pkg::joy_word_t exp_joy1;
    mister_pkg::joy_word_t exp_joy2;
    mister_pkg::joy_word_t exp_joy3;
    mister_pkg::joy_word_t exp_joy4;

    // Slot table indexed by the two port enables
    always_comb begin
        exp_joy1 = db15.ena1 ? game_layout(db15.joy1) : usb_joy1;
        exp_joy2 = db15.ena2 ? game_layout(db15.joy2) : usb_joy2;
        exp_joy3 = usb_joy3;
        exp_joy4 = usb_joy4;
        if (db15.ena1) begin
            if (!db15.ena2) begin
                exp_joy2 = usb_joy1;
            end
            exp_joy3 = usb_joy1;
            exp_joy4 = usb_joy2;
        end else if (db15.ena2) begin
            exp_joy3 = usb_joy2;
            exp_joy4 = usb_joy3;
        end
    end

    // Ring buffers of past hs ticks and past line starts
    logic [RING-1:0]   hs_ring;
    logic [RING-1:0]   vs_ring;
    logic [`OFS_W-1:0] hs_ptr;
    logic [`OFS_W-1:0] vs_ptr;
    logic [`OFS_W-1:0] hs_idx;
    logic [`OFS_W-1:0] vs_idx;
    logic              prev_hs;
    logic              exp_hs;
    logic              exp_vs;

    assign hs_idx = hs_ptr - hoffset;
    assign vs_idx = vs_ptr - voffset;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_ring <= '0;
            vs_ring <= '0;
            hs_ptr  <= '0;
            vs_ptr  <= '0;
            prev_hs <= 1'b0;
            exp_hs  <= 1'b0;
            exp_vs  <= 1'b0;
        end else if (pxl_cen) begin
            hs_ring[hs_ptr] <= game_sync.hs;
            hs_ptr          <= hs_ptr + 1'b1;
            prev_hs         <= game_sync.hs;
            if (game_sync.hs && !prev_hs) begin
                vs_ring[vs_ptr] <= game_sync.vs;
                vs_ptr          <= vs_ptr + 1'b1;
            end
            exp_hs <= (hoffset == 0) ? game_sync.hs : hs_ring[hs_idx];
            exp_vs <= (voffset == 0) ? game_sync.vs : vs_ring[vs_idx];
        end
    end

    // Expected DDR owner
    mister_pkg::ddr_owner_e exp_own;
    mister_pkg::ddr_req_t   own_req;
    logic                   exp_ld_busy;
    logic                   exp_rot_busy;

    assign own_req      = (exp_own == mister_pkg::OWN_LOAD) ? ld_req : rot_req;
    assign exp_ld_busy  = (exp_own == mister_pkg::OWN_LOAD) ? ddram_busy : 1'b1;
    assign exp_rot_busy = (exp_own == mister_pkg::OWN_ROT) ? ddram_busy : 1'b1;

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            exp_own <= mister_pkg::OWN_ROT;
        end else if (!own_req.rd && !own_req.we) begin
            if (downloading) begin
                exp_own <= mister_pkg::OWN_LOAD;
            end else begin
                exp_own <= mister_pkg::OWN_ROT;
            end
        end
    end

    a_joy1: assert property (@(posedge clk_sys) disable iff (!arst_n) game_joy1 == exp_joy1)
        else begin
            fail_count++;
            $error("Fail at %0t: game_joy1 = %h, expected %h",
                   $time, $sampled(game_joy1), $sampled(exp_joy1));
        end

    a_joy2: assert property (@(posedge clk_sys) disable iff (!arst_n) game_joy2 == exp_joy2)
        else begin
            fail_count++;
            $error("Fail at %0t: game_joy2 = %h, expected %h",
                   $time, $sampled(game_joy2), $sampled(exp_joy2));
        end

    a_joy3: assert property (@(posedge clk_sys) disable iff (!arst_n) game_joy3 == exp_joy3)
        else begin
            fail_count++;
            $error("Fail at %0t: game_joy3 = %h, expected %h",
                   $time, $sampled(game_joy3), $sampled(exp_joy3));
        end

    a_joy4: assert property (@(posedge clk_sys) disable iff (!arst_n) game_joy4 == exp_joy4)
        else begin
            fail_count++;
            $error("Fail at %0t: game_joy4 = %h, expected %h",
                   $time, $sampled(game_joy4), $sampled(exp_joy4));
        end

    a_hs: assert property (@(posedge clk_sys) disable iff (!arst_n) sync_out.hs == exp_hs)
        else begin
            fail_count++;
            $error("Fail at %0t: sync_out.hs = %b, expected %b",
                   $time, $sampled(sync_out.hs), $sampled(exp_hs));
        end

    a_vs: assert property (@(posedge clk_sys) disable iff (!arst_n) sync_out.vs == exp_vs)
        else begin
            fail_count++;
            $error("Fail at %0t: sync_out.vs = %b, expected %b",
                   $time, $sampled(sync_out.vs), $sampled(exp_vs));
        end

    a_ddr_req: assert property (@(posedge clk_rom) disable iff (!arst_n) ddr_req == own_req)
        else begin
            fail_count++;
            $error("Fail at %0t: ddr_req = %h, expected %h",
                   $time, $sampled(ddr_req), $sampled(own_req));
        end

    a_ld_busy: assert property (@(posedge clk_rom) disable iff (!arst_n) ld_busy == exp_ld_busy)
        else begin
            fail_count++;
            $error("Fail at %0t: ld_busy = %b, expected %b",
                   $time, $sampled(ld_busy), $sampled(exp_ld_busy));
        end

    a_rot_busy: assert property (@(posedge clk_rom) disable iff (!arst_n) rot_busy == exp_rot_busy)
        else begin
            fail_count++;
            $error("Fail at %0t: rot_busy = %b, expected %b",
                   $time, $sampled(rot_busy), $sampled(exp_rot_busy));
        end

endmodule

bind mister_frame mister_frame_asserts u_asserts (.*);

`default_nettype wire

// ==== hw/mister_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mister_defs.svh"

module mister_frame (
    input  wire                         clk_sys,
    input  wire                         clk_rom,
    input  wire                         arst_n,
    input  wire [`STATUS_W-1:0]         status,
    // Joysticks
    input  wire mister_pkg::db15_pair_t db15,
    input  wire mister_pkg::joy_word_t  usb_joy1,
    input  wire mister_pkg::joy_word_t  usb_joy2,
    input  wire mister_pkg::joy_word_t  usb_joy3,
    input  wire mister_pkg::joy_word_t  usb_joy4,
    output wire mister_pkg::joy_word_t  game_joy1,
    output wire mister_pkg::joy_word_t  game_joy2,
    output wire mister_pkg::joy_word_t  game_joy3,
    output wire mister_pkg::joy_word_t  game_joy4,
    // Video sync
    input  wire                         pxl_cen,
    input  wire mister_pkg::sync_t      game_sync,
    output wire mister_pkg::sync_t      sync_out,
    // DDR sharing
    input  wire                         downloading,
    input  wire                         ddram_busy,
    input  wire mister_pkg::ddr_req_t   ld_req,
    input  wire mister_pkg::ddr_req_t   rot_req,
    output wire mister_pkg::ddr_req_t   ddr_req,
    output wire                         ld_busy,
    output wire                         rot_busy
);

    wire [`OFS_W-1:0] hoffset;
    wire [`OFS_W-1:0] voffset;

    assign hoffset = status[`ST_HOFS_LSB +: `OFS_W];
    assign voffset = status[`ST_VOFS_LSB +: `OFS_W];

    joy_merge u_joy (
        .db15       ( db15        ),
        .usb_joy1   ( usb_joy1    ),
        .usb_joy2   ( usb_joy2    ),
        .usb_joy3   ( usb_joy3    ),
        .usb_joy4   ( usb_joy4    ),
        .game_joy1  ( game_joy1   ),
        .game_joy2  ( game_joy2   ),
        .game_joy3  ( game_joy3   ),
        .game_joy4  ( game_joy4   )
    );

    sync_offset u_sync (
        .clk_sys    ( clk_sys     ),
        .arst_n     ( arst_n      ),
        .pxl_cen    ( pxl_cen     ),
        .sync_in    ( game_sync   ),
        .hoffset    ( hoffset     ),
        .voffset    ( voffset     ),
        .sync_out   ( sync_out    )
    );

    ddr_arbiter u_ddr (
        .clk_rom    ( clk_rom     ),
        .arst_n     ( arst_n      ),
        .downloading( downloading ),
        .ld_req     ( ld_req      ),
        .rot_req    ( rot_req     ),
        .ddram_busy ( ddram_busy  ),
        .ddr_req    ( ddr_req     ),
        .ld_busy    ( ld_busy     ),
        .rot_busy   ( rot_busy    )
    );

endmodule

`default_nettype wire

// ==== hw/ddr_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mister_defs.svh"

module ddr_arbiter (
    input  wire                       clk_rom,
    input  wire                       arst_n,
    input  wire                       downloading,
    input  wire mister_pkg::ddr_req_t ld_req,
    input  wire mister_pkg::ddr_req_t rot_req,
    input  wire                       ddram_busy,
    output wire mister_pkg::ddr_req_t ddr_req,
    output wire                       ld_busy,
    output wire                       rot_busy
);

    mister_pkg::ddr_owner_e owner;
    mister_pkg::ddr_owner_e owner_nxt;
    mister_pkg::ddr_req_t   cur_req;
    logic                   cur_idle;

    assign cur_req  = (owner == mister_pkg::OWN_LOAD) ? ld_req : rot_req;

    // Owner counts as idle only with both rd and we low
    assign cur_idle = ~cur_req.rd & ~cur_req.we;

    // Loader gets the port during downloads, rotator the rest of the time
    always_comb begin
        owner_nxt = owner;
        if (cur_idle) begin
            if (downloading) begin
                owner_nxt = mister_pkg::OWN_LOAD;
            end else begin
                owner_nxt = mister_pkg::OWN_ROT;
            end
        end
    end

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            owner <= mister_pkg::OWN_ROT;
        end else begin
            owner <= owner_nxt;
        end
    end

    assign ddr_req = cur_req;

    // Non-owner is held off with a permanent busy
    assign ld_busy  = (owner == mister_pkg::OWN_LOAD) ? ddram_busy : 1'b1;
    assign rot_busy = (owner == mister_pkg::OWN_ROT)  ? ddram_busy : 1'b1;

endmodule

`default_nettype wire

// ==== hw/sync_offset.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mister_defs.svh"

module sync_offset (
    input  wire                    clk_sys,
    input  wire                    arst_n,
    input  wire                    pxl_cen,
    input  wire mister_pkg::sync_t sync_in,
    input  wire [`OFS_W-1:0]       hoffset,
    input  wire [`OFS_W-1:0]       voffset,
    output mister_pkg::sync_t      sync_out
);

    localparam int DEPTH = 1 << `OFS_W;

    // Past samples, index 0 is the most recent
    logic [DEPTH-2:0] hs_hist;
    logic [DEPTH-2:0] vs_hist;

    // Tap k holds the sample k steps back, tap 0 is the live input
    logic [DEPTH-1:0] hs_taps;
    logic [DEPTH-1:0] vs_taps;

    logic             line_start;

    assign hs_taps = {hs_hist, sync_in.hs};
    assign vs_taps = {vs_hist, sync_in.vs};

    // Rising hs against the previous pixel sample
    assign line_start = sync_in.hs & ~hs_hist[0];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_hist  <= '0;
            vs_hist  <= '0;
            sync_out <= '0;
        end else if (pxl_cen) begin
            // hs history moves every pixel
            hs_hist <= hs_taps[DEPTH-2:0];
            // vs history moves once per line
            if (line_start) begin
                vs_hist <= vs_taps[DEPTH-2:0];
            end
            sync_out.hs <= hs_taps[hoffset];
            sync_out.vs <= vs_taps[voffset];
        end
    end

endmodule

`default_nettype wire

// ==== hw/joy_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

module joy_merge (
    input  wire mister_pkg::db15_pair_t db15,
    input  wire mister_pkg::joy_word_t  usb_joy1,
    input  wire mister_pkg::joy_word_t  usb_joy2,
    input  wire mister_pkg::joy_word_t  usb_joy3,
    input  wire mister_pkg::joy_word_t  usb_joy4,
    output wire mister_pkg::joy_word_t  game_joy1,
    output wire mister_pkg::joy_word_t  game_joy2,
    output wire mister_pkg::joy_word_t  game_joy3,
    output wire mister_pkg::joy_word_t  game_joy4
);

    // DB15 raw word to game layout
    function automatic mister_pkg::joy_word_t db15_format(
        input logic [$bits(mister_pkg::joy_word_t)-1:0] raw
    );
        mister_pkg::joy_word_t j;
        j       = '0;
        j.dir   = raw[3:0];
        j.btn   = raw[4 +: $bits(j.btn)];
        j.start = raw[10];
        // Start held with button 5 also counts as coin
        j.coin  = raw[11] | (raw[10] & raw[5]);
        return j;
    endfunction

    mister_pkg::joy_word_t db_joy1;
    mister_pkg::joy_word_t db_joy2;

    assign db_joy1 = db15_format(db15.joy1);
    assign db_joy2 = db15_format(db15.joy2);

    // DB15 pads take the first slots, USB pads move up behind them
    assign game_joy1 = db15.ena1 ? db_joy1  : usb_joy1;

    assign game_joy2 = db15.ena2 ? db_joy2  :
                       db15.ena1 ? usb_joy1 : usb_joy2;

    assign game_joy3 = db15.ena1 ? usb_joy1 :
                       db15.ena2 ? usb_joy2 : usb_joy3;

    assign game_joy4 = db15.ena1 ? usb_joy2 :
                       db15.ena2 ? usb_joy3 : usb_joy4;

endmodule

`default_nettype wire

// ==== hw/mister_pkg.sv ====
`default_nettype none

`include "mister_defs.svh"

package mister_pkg;

    // Game side joystick word, coin on top
    typedef struct packed {
        logic                              coin;
        logic                              start;
        logic [`JOY_W-7-`BUTTONS:0]        rsvd;
        logic [`BUTTONS-1:0]               btn;
        logic [3:0]                        dir;
    } joy_word_t;

    // Raw words from the two DB15 ports
    typedef struct packed {
        logic [`JOY_W-1:0] joy2;
        logic [`JOY_W-1:0] joy1;
        logic              ena2;
        logic              ena1;
    } db15_pair_t;

    // One requester's command to the DDR port
    typedef struct packed {
        logic [`DDR_BCW-1:0]  burstcnt;
        logic [`DDR_AW-1:0]   addr;
        logic [`DDR_DW-1:0]   din;
        logic [`DDR_DW/8-1:0] be;
        logic                 rd;
        logic                 we;
    } ddr_req_t;

    typedef enum logic {
        OWN_ROT  = 1'b0,
        OWN_LOAD = 1'b1
    } ddr_owner_e;

    typedef struct packed {
        logic hs;
        logic vs;
    } sync_t;

endpackage

`default_nettype wire

// ==== hw/mister_defs.svh ====
`ifndef MISTER_DEFS_SVH
`define MISTER_DEFS_SVH

// Joystick word layout
`define JOY_W       16
`define BUTTONS     2

// DDR port widths
`define DDR_AW      29
`define DDR_DW      64
`define DDR_BCW     8

// Status word and the sync offset fields in it
`define STATUS_W    64
`define ST_HOFS_LSB 24
`define ST_VOFS_LSB 28
`define OFS_W       4

`endif
